/* src/mmu_settings.svh */
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Core bus data width in bits
`define MMU_MEM_W 32

// Number of GPIO pin cells
`define MMU_GPIO_PINS 10

// Scratch SRAM depth in bus words
`define MMU_SRAM_WORDS 1024

// GPIO direction registers, one address per pin
`define MMU_GPIO_DIR_BASE 32'h0000_0101

// GPIO pin values, one address per pin
`define MMU_GPIO_VAL_BASE 32'h0000_010B

// Countdown timer
`define MMU_TIMER_ADDR 32'h0000_0115

// Page number of the 4 KiB scratch window at 0x1000
`define MMU_SRAM_PAGE 20'h00001

`endif

/* src/bus_pkg.sv */
`include "mmu_settings.svh"

package bus_pkg;

    // Page and offset view of a core address
    typedef struct packed {
        logic [19:0] page;
        logic [11:0] offset;
    } mem_addr_s_t;

    // One address word, decoded either whole or as page plus offset
    typedef union packed {
        logic [31:0] raw;
        mem_addr_s_t f;
    } mem_addr_u;

    // Request from the core, valid for the single cycle req is high
    typedef struct packed {
        logic                    req;
        logic                    we;
        logic [`MMU_MEM_W/8-1:0] be;
        mem_addr_u               addr;
        logic [`MMU_MEM_W-1:0]   wdata;
    } mem_req_t;

    // Response to the core, exactly one of rvalid or err per request
    typedef struct packed {
        logic                  rvalid;
        logic                  err;
        logic [`MMU_MEM_W-1:0] rdata;
    } mem_rsp_t;

endpackage : bus_pkg

/* src/periph_pkg.sv */
`include "mmu_settings.svh"

package periph_pkg;

    // Region a request falls into
    typedef enum logic [2:0] {
        REG_NONE,
        REG_ERROR,
        REG_GPIO,
        REG_TIMER,
        REG_SRAM
    } region_e;

    // Pin number within the GPIO block
    typedef logic [$clog2(`MMU_GPIO_PINS)-1:0] pin_idx_t;

    // Word index into the scratch SRAM
    typedef logic [$clog2(`MMU_SRAM_WORDS)-1:0] sram_addr_t;

    // Strobe from the decoder to one pin cell
    typedef struct packed {
        logic sel;
        logic we;
        logic is_dir;
        logic wbit;
    } gpio_ctrl_t;

    // Registered result of one pin cell
    typedef struct packed {
        logic rbit;
        logic err;
    } gpio_rsp_t;

endpackage : periph_pkg

/* src/mmu_decoder.sv */
`include "mmu_settings.svh"

module mmu_decoder (
    input  logic                                         clk,
    input  logic                                         rst,
    input  bus_pkg::mem_req_t                            req_i,
    output periph_pkg::gpio_ctrl_t [`MMU_GPIO_PINS-1:0]  gpio_ctrl_o,
    output logic                                         timer_load_o,
    output logic [`MMU_MEM_W-1:0]                        timer_val_o,
    output logic                                         sram_en_o,
    output logic                                         sram_we_o,
    output logic [`MMU_MEM_W/8-1:0]                      sram_be_o,
    output periph_pkg::sram_addr_t                       sram_addr_o,
    output logic [`MMU_MEM_W-1:0]                        sram_wdata_o,
    output periph_pkg::region_e                          sel_region_o,
    output periph_pkg::pin_idx_t                         sel_pin_o,
    output logic                                         sel_we_o
);

    periph_pkg::region_e  region;
    periph_pkg::pin_idx_t pin_idx;
    logic [31:0]          dir_off;
    logic [31:0]          val_off;
    logic                 in_dir;
    logic                 in_val;

    // Offsets into the two GPIO windows; below the base they wrap to a large value
    assign dir_off = req_i.addr.raw - `MMU_GPIO_DIR_BASE;
    assign val_off = req_i.addr.raw - `MMU_GPIO_VAL_BASE;
    assign in_dir  = dir_off < `MMU_GPIO_PINS;
    assign in_val  = val_off < `MMU_GPIO_PINS;

    assign pin_idx = in_dir ? periph_pkg::pin_idx_t'(dir_off) : periph_pkg::pin_idx_t'(val_off);

    // Raw compare for GPIO and timer, page compare for the SRAM window
    always_comb begin
        region = periph_pkg::REG_NONE;
        if (req_i.req) begin
            if (in_dir || in_val) begin
                region = periph_pkg::REG_GPIO;
            end else if (req_i.addr.raw == `MMU_TIMER_ADDR) begin
                region = periph_pkg::REG_TIMER;
            end else if (req_i.addr.f.page == `MMU_SRAM_PAGE) begin
                region = periph_pkg::REG_SRAM;
            end else begin
                // Reserved ranges and every external page
                region = periph_pkg::REG_ERROR;
            end
        end
    end

    // Only the addressed pin sees sel
    always_comb begin
        for (int p = 0; p < `MMU_GPIO_PINS; p++) begin
            gpio_ctrl_o[p].sel    = (region == periph_pkg::REG_GPIO) &&
                                    (pin_idx == periph_pkg::pin_idx_t'(p));
            gpio_ctrl_o[p].we     = req_i.we;
            gpio_ctrl_o[p].is_dir = in_dir;
            gpio_ctrl_o[p].wbit   = req_i.wdata[0];
        end
    end

    assign timer_load_o = (region == periph_pkg::REG_TIMER) && req_i.we;
    assign timer_val_o  = req_i.wdata;

    // SRAM is word addressed, byte lanes go through be
    assign sram_en_o    = region == periph_pkg::REG_SRAM;
    assign sram_we_o    = req_i.we;
    assign sram_be_o    = req_i.be;
    assign sram_addr_o  = req_i.addr.f.offset[2 +: $bits(periph_pkg::sram_addr_t)];
    assign sram_wdata_o = req_i.wdata;

    // Selection seen by the response collector one cycle later
    always_ff @(posedge clk) begin
        if (!rst) begin
            sel_region_o <= periph_pkg::REG_NONE;
            sel_pin_o    <= '0;
            sel_we_o     <= 1'b0;
        end else begin
            sel_region_o <= region;
            sel_pin_o    <= pin_idx;
            sel_we_o     <= req_i.we;
        end
    end

endmodule : mmu_decoder

/* src/gpio_pin.sv */
module gpio_pin (
    input  logic                   clk,
    input  logic                   rst,
    input  periph_pkg::gpio_ctrl_t ctrl_i,
    input  logic                   pin_i,
    output logic                   pin_o,
    output logic                   oe_o,
    output periph_pkg::gpio_rsp_t  rsp_o
);

    // 1 means input
    logic dir;
    logic val;
    logic err_d;
    logic rbit_d;

    // Value access must match the current direction
    assign err_d  = ctrl_i.sel && !ctrl_i.is_dir && (ctrl_i.we ? dir : !dir);
    assign rbit_d = ctrl_i.is_dir ? dir : pin_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            dir   <= 1'b1;
            val   <= 1'b0;
            rsp_o <= '0;
        end else begin
            if (ctrl_i.sel && ctrl_i.we && ctrl_i.is_dir) begin
                dir <= ctrl_i.wbit;
            end
            if (ctrl_i.sel && ctrl_i.we && !ctrl_i.is_dir && !dir) begin
                val <= ctrl_i.wbit;
            end
            rsp_o.err  <= err_d;
            rsp_o.rbit <= rbit_d;
        end
    end

    assign pin_o = val;
    assign oe_o  = !dir;

endmodule : gpio_pin

/* src/digital_timer.sv */
`include "mmu_settings.svh"

module digital_timer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_i,
    input  logic [`MMU_MEM_W-1:0] val_i,
    output logic                  busy_o
);

    logic [`MMU_MEM_W-1:0] count;

    // A load wins over the decrement in the same cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else if (load_i) begin
            count <= val_i;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Stays high until the count runs out
    assign busy_o = count != '0;

endmodule : digital_timer

/* src/scratch_sram.sv */
`include "mmu_settings.svh"

module scratch_sram (
    input  logic                    clk,
    input  logic                    en_i,
    input  logic                    we_i,
    input  logic [`MMU_MEM_W/8-1:0] be_i,
    input  periph_pkg::sram_addr_t  addr_i,
    input  logic [`MMU_MEM_W-1:0]   wdata_i,
    output logic [`MMU_MEM_W-1:0]   rdata_o
);

    logic [`MMU_MEM_W-1:0] mem [`MMU_SRAM_WORDS];

    // Single port, read data one cycle after the access
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < `MMU_MEM_W / 8; b++) begin
                    if (be_i[b]) begin
                        mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
            // Old word on a write, the collector drops it anyway
            rdata_o <= mem[addr_i];
        end
    end

endmodule : scratch_sram

/* src/mmu_response.sv */
`include "mmu_settings.svh"

module mmu_response (
    input  periph_pkg::region_e                          sel_region_i,
    input  periph_pkg::pin_idx_t                         sel_pin_i,
    input  logic                                         sel_we_i,
    input  periph_pkg::gpio_rsp_t [`MMU_GPIO_PINS-1:0]   gpio_rsp_i,
    input  logic                                         timer_busy_i,
    input  logic [`MMU_MEM_W-1:0]                        sram_rdata_i,
    output bus_pkg::mem_rsp_t                            rsp_o
);

    periph_pkg::gpio_rsp_t pin_rsp;

    // Result of the pin that was addressed last cycle
    assign pin_rsp = gpio_rsp_i[sel_pin_i];

    always_comb begin
        rsp_o = '0;
        unique case (sel_region_i)
            periph_pkg::REG_ERROR: begin
                rsp_o.err = 1'b1;
            end
            periph_pkg::REG_GPIO: begin
                // Pin decides its own access errors
                rsp_o.err    = pin_rsp.err;
                rsp_o.rvalid = !pin_rsp.err;
                rsp_o.rdata  = {{(`MMU_MEM_W-1){1'b0}}, pin_rsp.rbit};
            end
            periph_pkg::REG_TIMER: begin
                rsp_o.rvalid = 1'b1;
                rsp_o.rdata  = {{(`MMU_MEM_W-1){1'b0}}, timer_busy_i};
            end
            periph_pkg::REG_SRAM: begin
                rsp_o.rvalid = 1'b1;
                rsp_o.rdata  = sram_rdata_i;
            end
            default: begin
                // No request last cycle, nothing to answer
                rsp_o = '0;
            end
        endcase

        // Writes and errors carry no data
        if (sel_we_i || rsp_o.err) begin
            rsp_o.rdata = '0;
        end
    end

endmodule : mmu_response

/* src/mmu.sv */
`include "mmu_settings.svh"

module mmu (
    input  logic                      clk,
    input  logic                      rst,
    input  bus_pkg::mem_req_t         req_i,
    input  logic [`MMU_GPIO_PINS-1:0] gpio_i,
    output bus_pkg::mem_rsp_t         rsp_o,
    output logic [`MMU_GPIO_PINS-1:0] gpio_o,
    output logic [`MMU_GPIO_PINS-1:0] gpio_oe_o
);

    periph_pkg::gpio_ctrl_t [`MMU_GPIO_PINS-1:0] gpio_ctrl;
    periph_pkg::gpio_rsp_t  [`MMU_GPIO_PINS-1:0] gpio_rsp;

    logic                    timer_load;
    logic [`MMU_MEM_W-1:0]   timer_val;
    logic                    timer_busy;

    logic                    sram_en;
    logic                    sram_we;
    logic [`MMU_MEM_W/8-1:0] sram_be;
    periph_pkg::sram_addr_t  sram_addr;
    logic [`MMU_MEM_W-1:0]   sram_wdata;
    logic [`MMU_MEM_W-1:0]   sram_rdata;

    periph_pkg::region_e     sel_region;
    periph_pkg::pin_idx_t    sel_pin;
    logic                    sel_we;

    mmu_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .gpio_ctrl_o  (gpio_ctrl),
        .timer_load_o (timer_load),
        .timer_val_o  (timer_val),
        .sram_en_o    (sram_en),
        .sram_we_o    (sram_we),
        .sram_be_o    (sram_be),
        .sram_addr_o  (sram_addr),
        .sram_wdata_o (sram_wdata),
        .sel_region_o (sel_region),
        .sel_pin_o    (sel_pin),
        .sel_we_o     (sel_we)
    );

    // One cell per pin, pads split into in, out and enable
    for (genvar i = 0; i < `MMU_GPIO_PINS; i++) begin : g_pin
        gpio_pin u_pin (
            .clk    (clk),
            .rst    (rst),
            .ctrl_i (gpio_ctrl[i]),
            .pin_i  (gpio_i[i]),
            .pin_o  (gpio_o[i]),
            .oe_o   (gpio_oe_o[i]),
            .rsp_o  (gpio_rsp[i])
        );
    end

    digital_timer u_timer (
        .clk    (clk),
        .rst    (rst),
        .load_i (timer_load),
        .val_i  (timer_val),
        .busy_o (timer_busy)
    );

    scratch_sram u_sram (
        .clk     (clk),
        .en_i    (sram_en),
        .we_i    (sram_we),
        .be_i    (sram_be),
        .addr_i  (sram_addr),
        .wdata_i (sram_wdata),
        .rdata_o (sram_rdata)
    );

    mmu_response u_response (
        .sel_region_i (sel_region),
        .sel_pin_i    (sel_pin),
        .sel_we_i     (sel_we),
        .gpio_rsp_i   (gpio_rsp),
        .timer_busy_i (timer_busy),
        .sram_rdata_i (sram_rdata),
        .rsp_o        (rsp_o)
    );

endmodule : mmu

/* tests/mmu_assert.sv */
module mmu_assert (
    input logic              clk,
    input logic              rst,
    input bus_pkg::mem_req_t req_i,
    input bus_pkg::mem_rsp_t rsp_i
);

    // Every request gets exactly one answer in the next cycle
    a_one_answer: assert property (@(posedge clk) disable iff (!rst)
        req_i.req |=> (rsp_i.rvalid ^ rsp_i.err))
        else $error("Request not followed by exactly one of rvalid or err");

    a_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(rsp_i.rvalid && rsp_i.err))
        else $error("rvalid and err high in the same cycle");

    // An idle cycle leaves the next one quiet
    a_no_spurious: assert property (@(posedge clk) disable iff (!rst)
        !req_i.req |=> !(rsp_i.rvalid || rsp_i.err))
        else $error("Response raised without a request");

endmodule : mmu_assert

bind mmu mmu_assert u_assert (
    .clk   (clk),
    .rst   (rst),
    .req_i (req_i),
    .rsp_i (rsp_o)
);

/* tests/mmu_tb.sv */
`include "mmu_settings.svh"

module mmu_tb;

    localparam logic [31:0] DIR = `MMU_GPIO_DIR_BASE;
    localparam logic [31:0] VAL = `MMU_GPIO_VAL_BASE;
    localparam logic [31:0] TMR = `MMU_TIMER_ADDR;

    typedef struct packed {
        logic                      we;
        logic [31:0]               addr;
        logic [3:0]                be;
        logic [31:0]               wdata;
        logic [`MMU_GPIO_PINS-1:0] gpio;
        logic                      exp_err;
        logic [31:0]               exp_rdata;
        // Random SRAM data with reads predicted by the memory model
        logic                      rnd;
    } step_t;

    logic                      clk;
    logic                      rst;
    bus_pkg::mem_req_t         req;
    bus_pkg::mem_rsp_t         rsp;
    logic [`MMU_GPIO_PINS-1:0] gpio_in;
    logic [`MMU_GPIO_PINS-1:0] gpio_out;
    logic [`MMU_GPIO_PINS-1:0] gpio_oe;

    step_t                     steps[$];
    step_t                     cur;
    logic [31:0]               sram_model [`MMU_SRAM_WORDS];
    logic [`MMU_GPIO_PINS-1:0] dir_model;
    logic [`MMU_GPIO_PINS-1:0] val_model;
    logic [31:0]               reserved [6];
    int                        cycles = 0;
    int                        limit = 50;

    mmu dut_i (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req),
        .gpio_i    (gpio_in),
        .rsp_o     (rsp),
        .gpio_o    (gpio_out),
        .gpio_oe_o (gpio_oe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run();
        $display("TB FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_value(input string name, input int idx,
                                input logic [31:0] got, input logic [31:0] exp);
        $display("** Error: step %0d %s = 0x%0h, expected 0x%0h", idx, name, got, exp);
        fail_run();
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: test still running after %0d cycles", cycles);
            fail_run();
        end
    end

    task automatic add_step(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, input logic [`MMU_GPIO_PINS-1:0] gpio,
                            input logic exp_err, input logic [31:0] exp_rdata, input logic rnd);
        steps.push_back(step_t'{we, addr, be, wdata, gpio, exp_err, exp_rdata, rnd});
    endtask

    task automatic build_table();
        reserved = '{32'h0, 32'h100, 32'h116, 32'hFFF, 32'h2000, 32'h8000_0000};
        foreach (reserved[k]) begin
            add_step(1'b0, reserved[k], 4'hF, 32'h0, '0, 1'b1, 32'h0, 1'b0);
            add_step(1'b1, reserved[k], 4'hF, 32'hDEAD_BEEF, '0, 1'b1, 32'h0, 1'b0);
        end
        // Directions come out of reset as inputs
        for (int p = 0; p < `MMU_GPIO_PINS; p++) begin
            add_step(1'b0, DIR + p, 4'hF, 32'h0, '0, 1'b0, 32'h1, 1'b0);
        end
        add_step(1'b1, VAL + 3, 4'hF, 32'h1, '0, 1'b1, 32'h0, 1'b0);
        add_step(1'b0, VAL + 3, 4'hF, 32'h0, 10'h008, 1'b0, 32'h1, 1'b0);
        add_step(1'b0, VAL + 3, 4'hF, 32'h0, 10'h3F7, 1'b0, 32'h0, 1'b0);
        // Pin 3 turned to output
        add_step(1'b1, DIR + 3, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b0, DIR + 3, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b1, VAL + 3, 4'hF, 32'h1, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b0, VAL + 3, 4'hF, 32'h0, '0, 1'b1, 32'h0, 1'b0);
        add_step(1'b1, DIR + 9, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b1, VAL + 9, 4'hF, 32'h1, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b1, DIR + 3, 4'hF, 32'h1, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b0, VAL + 3, 4'hF, 32'h0, 10'h008, 1'b0, 32'h1, 1'b0);
        // Load 3 and watch the count run out
        add_step(1'b1, TMR, 4'hF, 32'h3, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b0, TMR, 4'hF, 32'h0, '0, 1'b0, 32'h1, 1'b0);
        add_step(1'b0, TMR, 4'hF, 32'h0, '0, 1'b0, 32'h1, 1'b0);
        add_step(1'b0, TMR, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b1, 32'h1000, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        add_step(1'b1, 32'h1004, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        add_step(1'b0, 32'h1000, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        add_step(1'b1, 32'h1000, 4'h5, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        add_step(1'b1, 32'h1004, 4'hA, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        add_step(1'b0, 32'h1000, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        add_step(1'b1, 32'h1FFC, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        add_step(1'b1, 32'h1FFC, 4'h3, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        add_step(1'b0, 32'h1FFC, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        // Mixed regions back to back
        add_step(1'b1, TMR, 4'hF, 32'h2, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b0, TMR, 4'hF, 32'h0, '0, 1'b0, 32'h1, 1'b0);
        add_step(1'b0, 32'h1004, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b1);
        add_step(1'b0, DIR + 9, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b0);
        add_step(1'b0, 32'h0, 4'hF, 32'h0, '0, 1'b1, 32'h0, 1'b0);
        add_step(1'b1, VAL + 9, 4'hF, 32'h0, '0, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic check_response(input step_t s, input int idx);
        logic [31:0] exp_rdata;
        int          w;
        int          pin;
        exp_rdata = s.exp_rdata;
        w = int'(s.addr[11:2]);
        if (s.rnd && !s.we) begin
            exp_rdata = sram_model[w];
        end
        assert (rsp.err == s.exp_err)
            else report_value("rsp_o.err", idx, 32'(rsp.err), 32'(s.exp_err));
        assert (rsp.rvalid == !s.exp_err)
            else report_value("rsp_o.rvalid", idx, 32'(rsp.rvalid), 32'(!s.exp_err));
        assert (rsp.rdata == exp_rdata)
            else report_value("rsp_o.rdata", idx, rsp.rdata, exp_rdata);
        // SRAM merge by byte enable
        if (s.rnd && s.we) begin
            for (int b = 0; b < 4; b++) begin
                if (s.be[b]) begin
                    sram_model[w][b*8 +: 8] = s.wdata[b*8 +: 8];
                end
            end
        end
        if (s.we && s.addr >= DIR && s.addr < DIR + `MMU_GPIO_PINS) begin
            pin = int'(s.addr - DIR);
            dir_model[pin] = s.wdata[0];
        end
        // Value write lands only on an output pin
        if (s.we && s.addr >= VAL && s.addr < VAL + `MMU_GPIO_PINS) begin
            pin = int'(s.addr - VAL);
            if (!dir_model[pin]) begin
                val_model[pin] = s.wdata[0];
            end
        end
        assert (gpio_oe == ~dir_model)
            else report_value("gpio_oe_o", idx, 32'(gpio_oe), 32'(~dir_model));
        assert (gpio_out == val_model)
            else report_value("gpio_o", idx, 32'(gpio_out), 32'(val_model));
    endtask

    initial begin
        void'($urandom(21));
        rst       = 1'b0;
        req       = '0;
        gpio_in   = '0;
        dir_model = '1;
        val_model = '0;
        build_table();
        limit = steps.size() + 50;
        repeat (4) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        assert (gpio_oe == '0) else begin
            $display("** Error: after reset gpio_oe_o = 0x%0h, expected 0x0", gpio_oe);
            fail_run();
        end
        // One request per step and its response a cycle later
        for (int i = 0; i <= steps.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_response(cur, i - 1);
            end
            if (i < steps.size()) begin
                cur = steps[i];
                if (cur.rnd && cur.we) begin
                    cur.wdata = $urandom;
                end
                req.req      = 1'b1;
                req.we       = cur.we;
                req.be       = cur.be;
                req.addr.raw = cur.addr;
                req.wdata    = cur.wdata;
                gpio_in      = cur.gpio;
            end else begin
                req = '0;
            end
        end
        @(negedge clk);
        assert (!rsp.rvalid && !rsp.err) else begin
            $display("Response raised in a cycle after no request");
            fail_run();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule : mmu_tb

/* mmu.f */
+incdir+src
src/bus_pkg.sv
src/periph_pkg.sv
src/mmu_decoder.sv
src/gpio_pin.sv
src/digital_timer.sv
src/scratch_sram.sv
src/mmu_response.sv
src/mmu.sv
tests/mmu_assert.sv
tests/mmu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := mmu_tb
FILELIST   := mmu.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

SOURCES    := $(shell grep -v '^+' $(FILELIST)) src/mmu_settings.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
